// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= pipelineCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== pipelineCore.f ====
src/riscvPkg.sv
src/registerFile.sv
src/branchPredictor.sv
src/pipelineDatapath.sv
src/pipelineControl.sv
src/pipelineCore.sv
tb/clockGen.sv
tb/coreChecker.sv
tb/coreTb.sv

// ==== src/branchPredictor.sv ====
`timescale 1ns/1ps

module branchPredictor import riscvPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [xlen-1:0]        pcF_i,
    output logic                   predictTakenF_o,
    output logic [xlen-1:0]        targetF_o,
    output logic [bpIndexBits-1:0] phtIndexF_o,
    input  logic                   phtWe_i,
    input  logic                   phtInc_i,
    input  logic [bpIndexBits-1:0] phtIndex_i,
    input  logic                   ghrReset_i,
    input  logic                   btbWe_i,
    // Word address of the resolved instruction, low bits select the slot
    input  logic [xlen-3:0]        btbIndex_i,
    input  logic [xlen-1:0]        btbTarget_i
);

    logic [bpIndexBits-1:0] ghr;
    logic [1:0]             pht [bpEntries];
    logic [bpEntries-1:0]   btbValid;
    logic [btbTagBits-1:0]  btbTag [bpEntries];
    logic [xlen-1:0]        btbTarget [bpEntries];
    logic [bpIndexBits-1:0] slotF;
    logic [btbTagBits-1:0]  tagF;
    logic [bpIndexBits-1:0] slotW;

    assign slotF = pcF_i[bpIndexBits+1:2];
    assign tagF  = pcF_i[xlen-1:bpIndexBits+2];
    assign slotW = btbIndex_i[bpIndexBits-1:0];

    // gshare index
    assign phtIndexF_o = slotF ^ ghr;
    assign targetF_o   = btbTarget[slotF];
    assign predictTakenF_o = btbValid[slotF] && (btbTag[slotF] == tagF)
                             && pht[phtIndexF_o][1];

    // History and saturating counters
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < bpEntries; i++) begin
                pht[i] <= 2'b01;
            end
        end else begin
            if (ghrReset_i) begin
                ghr <= '0;
            end else if (phtWe_i) begin
                ghr <= {ghr[bpIndexBits-2:0], phtInc_i};
            end
            if (phtWe_i) begin
                if (phtInc_i && pht[phtIndex_i] != 2'b11) begin
                    pht[phtIndex_i] <= pht[phtIndex_i] + 2'd1;
                end else if (!phtInc_i && pht[phtIndex_i] != 2'b00) begin
                    pht[phtIndex_i] <= pht[phtIndex_i] - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
        end else if (btbWe_i) begin
            btbValid[slotW] <= 1'b1;
        end
    end

    // BTB payload
    always_ff @(posedge clk) begin
        if (btbWe_i) begin
            btbTag[slotW]    <= btbIndex_i[xlen-3:bpIndexBits];
            btbTarget[slotW] <= btbTarget_i;
        end
    end

endmodule

// ==== src/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl import riscvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [6:0]  opD_i,
    input  logic [2:0]  funct3D_i,
    input  logic        funct7b5D_i,
    input  logic [4:0]  rs1D_i,
    input  logic [4:0]  rs2D_i,
    input  logic [4:0]  rs1E_i,
    input  logic [4:0]  rs2E_i,
    input  logic [4:0]  rdE_i,
    input  logic [4:0]  rdM_i,
    input  logic [4:0]  rdW_i,
    input  logic        mispredictE_i,
    output immSrc_t     immSrcD_o,
    output logic        aluSrcE_o,
    output aluOp_t      aluOpE_o,
    output forwardSel_t forwardAE_o,
    output forwardSel_t forwardBE_o,
    output logic        memWriteM_o,
    output resultSrc_t  resultSrcM_o,
    output resultSrc_t  resultSrcW_o,
    output logic        regWriteW_o,
    output logic        stallF_o,
    output logic        stallD_o,
    output logic        flushD_o,
    output logic        flushE_o
);

    logic regWriteD, memWriteD, aluSrcD, regWriteE, memWriteE, regWriteM, loadUse;
    aluOp_t aluOpD, aluFunctD;
    resultSrc_t resultSrcD, resultSrcE;

    // ALU function shared by R-type and immediate ops
    always_comb begin
        case (funct3D_i)
            3'b111:  aluFunctD = aluAnd;
            3'b110:  aluFunctD = aluOr;
            3'b010:  aluFunctD = aluSlt;
            default: aluFunctD = aluAdd;
        endcase
    end

    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        aluOpD     = aluAdd;
        immSrcD_o  = immI;
        resultSrcD = resAlu;
        case (opD_i)
            opRtype: begin
                regWriteD = 1'b1;
                aluOpD    = (funct3D_i == 3'b000 && funct7b5D_i) ? aluSub : aluFunctD;
            end
            opItype: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = aluFunctD;
            end
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resMem;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = immS;
            end
            opBranch: begin
                aluOpD    = aluSub;
                immSrcD_o = immB;
            end
            opJal: begin
                regWriteD  = 1'b1;
                immSrcD_o  = immJ;
                resultSrcD = resPcPlus4;
            end
            opLui: begin
                regWriteD  = 1'b1;
                immSrcD_o  = immU;
                resultSrcD = resImm;
            end
            default: ;
        endcase
    end

    // Control pipeline, execute takes the bubble on flush
    always_ff @(posedge clk) begin
        if (reset || flushE_o) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            aluSrcE_o  <= 1'b0;
            aluOpE_o   <= aluAdd;
            resultSrcE <= resAlu;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            aluSrcE_o  <= aluSrcD;
            aluOpE_o   <= aluOpD;
            resultSrcE <= resultSrcD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM    <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= resAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= resAlu;
        end else begin
            regWriteM    <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE;
            regWriteW_o  <= regWriteM;
            resultSrcW_o <= resultSrcM_o;
        end
    end

    // Memory stage has priority over writeback
    always_comb begin
        if (rs1E_i != 5'd0 && regWriteM && rs1E_i == rdM_i) begin
            forwardAE_o = fwdMem;
        end else if (rs1E_i != 5'd0 && regWriteW_o && rs1E_i == rdW_i) begin
            forwardAE_o = fwdWb;
        end else begin
            forwardAE_o = fwdReg;
        end
        if (rs2E_i != 5'd0 && regWriteM && rs2E_i == rdM_i) begin
            forwardBE_o = fwdMem;
        end else if (rs2E_i != 5'd0 && regWriteW_o && rs2E_i == rdW_i) begin
            forwardBE_o = fwdWb;
        end else begin
            forwardBE_o = fwdReg;
        end
    end

    assign loadUse = (resultSrcE == resMem) && regWriteE && rdE_i != 5'd0
                     && (rs1D_i == rdE_i || rs2D_i == rdE_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = mispredictE_i;
    assign flushE_o = loadUse || mispredictE_i;

endmodule

// ==== src/pipelineCore.sv ====
`timescale 1ns/1ps

module pipelineCore import riscvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] pcF_o,
    input  logic [xlen-1:0] instrF_i,
    output logic [xlen-1:0] aluResultM_o,
    output logic [xlen-1:0] writeDataM_o,
    output logic            memWriteM_o,
    input  logic [xlen-1:0] readDataM_i,
    output logic            mispredictE_o
);

    logic [6:0] opD;
    logic [2:0] funct3D;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    logic [xlen-1:0] rd1D, rd2D, resultW, targetF, btbTarget;
    logic [xlen-3:0] btbIndex;
    logic [bpIndexBits-1:0] phtIndexF, phtIndex;
    logic funct7b5D, aluSrcE, regWriteW, stallF, stallD, flushD, flushE;
    logic predictTakenF, phtWe, phtInc, ghrReset, btbWe;
    immSrc_t immSrcD;
    aluOp_t aluOpE;
    forwardSel_t forwardAE, forwardBE;
    resultSrc_t resultSrcM, resultSrcW;

    pipelineControl control (
        .clk(clk), .reset(reset),
        .opD_i(opD), .funct3D_i(funct3D), .funct7b5D_i(funct7b5D),
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW), .mispredictE_i(mispredictE_o),
        .immSrcD_o(immSrcD), .aluSrcE_o(aluSrcE), .aluOpE_o(aluOpE),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE), .memWriteM_o(memWriteM_o),
        .resultSrcM_o(resultSrcM), .resultSrcW_o(resultSrcW), .regWriteW_o(regWriteW),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

    pipelineDatapath datapath (
        .clk(clk), .reset(reset),
        .pcF_o(pcF_o), .instrF_i(instrF_i), .predictTakenF_i(predictTakenF),
        .targetF_i(targetF), .phtIndexF_i(phtIndexF),
        .opD_o(opD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rd1D_i(rd1D), .rd2D_i(rd2D),
        .immSrcD_i(immSrcD), .stallF_i(stallF), .stallD_i(stallD),
        .flushD_i(flushD), .flushE_i(flushE),
        .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE), .aluSrcE_i(aluSrcE),
        .aluOpE_i(aluOpE), .forwardAE_i(forwardAE), .forwardBE_i(forwardBE),
        .mispredictE_o(mispredictE_o),
        .phtWe_o(phtWe), .phtInc_o(phtInc), .phtIndex_o(phtIndex), .ghrReset_o(ghrReset),
        .btbWe_o(btbWe), .btbIndex_o(btbIndex), .btbTarget_o(btbTarget),
        .rdM_o(rdM), .aluResultM_o(aluResultM_o), .writeDataM_o(writeDataM_o),
        .readDataM_i(readDataM_i), .resultSrcM_i(resultSrcM),
        .rdW_o(rdW), .resultSrcW_i(resultSrcW), .resultW_o(resultW)
    );

    registerFile regFile (
        .clk(clk), .addr1_i(rs1D), .addr2_i(rs2D), .addr3_i(rdW),
        .writeEn_i(regWriteW), .writeData_i(resultW), .data1_o(rd1D), .data2_o(rd2D)
    );

    branchPredictor predictor (
        .clk(clk), .reset(reset), .pcF_i(pcF_o),
        .predictTakenF_o(predictTakenF), .targetF_o(targetF), .phtIndexF_o(phtIndexF),
        .phtWe_i(phtWe), .phtInc_i(phtInc), .phtIndex_i(phtIndex), .ghrReset_i(ghrReset),
        .btbWe_i(btbWe), .btbIndex_i(btbIndex), .btbTarget_i(btbTarget)
    );

endmodule

// ==== src/pipelineDatapath.sv ====
`timescale 1ns/1ps

module pipelineDatapath import riscvPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic [xlen-1:0]        pcF_o,
    input  logic [xlen-1:0]        instrF_i,
    input  logic                   predictTakenF_i,
    input  logic [xlen-1:0]        targetF_i,
    input  logic [bpIndexBits-1:0] phtIndexF_i,
    output logic [6:0]             opD_o,
    output logic [2:0]             funct3D_o,
    output logic                   funct7b5D_o,
    output logic [4:0]             rs1D_o,
    output logic [4:0]             rs2D_o,
    input  logic [xlen-1:0]        rd1D_i,
    input  logic [xlen-1:0]        rd2D_i,
    input  immSrc_t                immSrcD_i,
    input  logic                   stallF_i,
    input  logic                   stallD_i,
    input  logic                   flushD_i,
    input  logic                   flushE_i,
    output logic [4:0]             rs1E_o,
    output logic [4:0]             rs2E_o,
    output logic [4:0]             rdE_o,
    input  logic                   aluSrcE_i,
    input  aluOp_t                 aluOpE_i,
    input  forwardSel_t            forwardAE_i,
    input  forwardSel_t            forwardBE_i,
    output logic                   mispredictE_o,
    output logic                   phtWe_o,
    output logic                   phtInc_o,
    output logic [bpIndexBits-1:0] phtIndex_o,
    output logic                   ghrReset_o,
    output logic                   btbWe_o,
    output logic [xlen-3:0]        btbIndex_o,
    output logic [xlen-1:0]        btbTarget_o,
    output logic [4:0]             rdM_o,
    output logic [xlen-1:0]        aluResultM_o,
    output logic [xlen-1:0]        writeDataM_o,
    input  logic [xlen-1:0]        readDataM_i,
    input  resultSrc_t             resultSrcM_i,
    output logic [4:0]             rdW_o,
    input  resultSrc_t             resultSrcW_i,
    output logic [xlen-1:0]        resultW_o
);

    logic [xlen-1:0] instrD, pcD, immD;
    logic [xlen-1:0] rd1E, rd2E, pcE, immE, srcAE, srcBE, writeDataE;
    logic [xlen-1:0] aluResultE, redirectE, pcPlus4M, immM, forwardDataM;
    logic [xlen-1:0] aluResultW, readDataW, pcPlus4W, immW;
    logic [bpIndexBits-1:0] phtIndexD, phtIndexE;
    logic [6:0] opE;
    logic [2:0] funct3E;
    logic predTakenD, predTakenE, zeroE, isBranchE, isJalE, branchTakenE;

    // Fetch: redirect wins over the BTB target
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= resetPc;
        end else if (mispredictE_o) begin
            pcF_o <= redirectE;
        end else if (!stallF_i) begin
            pcF_o <= predictTakenF_i ? targetF_i : pcF_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= '0;
            pcD        <= '0;
            predTakenD <= 1'b0;
            phtIndexD  <= '0;
        end else if (!stallD_i) begin
            instrD     <= instrF_i;
            pcD        <= pcF_o;
            predTakenD <= predictTakenF_i;
            phtIndexD  <= phtIndexF_i;
        end
    end

    assign opD_o       = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];
    assign rs1D_o      = instrD[19:15];
    assign rs2D_o      = instrD[24:20];

    always_comb begin
        case (immSrcD_i)
            immI:    immD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rd1E       <= '0;
            rd2E       <= '0;
            pcE        <= '0;
            immE       <= '0;
            rs1E_o     <= '0;
            rs2E_o     <= '0;
            rdE_o      <= '0;
            opE        <= '0;
            funct3E    <= '0;
            predTakenE <= 1'b0;
            phtIndexE  <= '0;
        end else begin
            rd1E       <= rd1D_i;
            rd2E       <= rd2D_i;
            pcE        <= pcD;
            immE       <= immD;
            rs1E_o     <= rs1D_o;
            rs2E_o     <= rs2D_o;
            rdE_o      <= instrD[11:7];
            opE        <= opD_o;
            funct3E    <= funct3D_o;
            predTakenE <= predTakenD;
            phtIndexE  <= phtIndexD;
        end
    end

    // Forwarding muxes
    always_comb begin
        case (forwardAE_i)
            fwdMem:  srcAE = forwardDataM;
            fwdWb:   srcAE = resultW_o;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            fwdMem:  writeDataE = forwardDataM;
            fwdWb:   writeDataE = resultW_o;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE_i ? immE : writeDataE;

    always_comb begin
        case (aluOpE_i)
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = srcAE + srcBE;
        endcase
    end

    assign zeroE = (aluResultE == '0);

    // Branch resolution against the prediction carried from fetch
    assign isBranchE = (opE == opBranch);
    assign isJalE    = (opE == opJal);
    assign branchTakenE = isBranchE && ((funct3E == f3Beq && zeroE)
                                        || (funct3E == f3Bne && !zeroE));
    assign redirectE = (branchTakenE || isJalE) ? pcE + immE : pcE + 32'd4;

    assign ghrReset_o    = isBranchE && (predTakenE != branchTakenE);
    assign mispredictE_o = ghrReset_o || (isJalE && !predTakenE);
    assign phtWe_o       = isBranchE;
    assign phtInc_o      = branchTakenE;
    assign phtIndex_o    = phtIndexE;
    assign btbWe_o       = branchTakenE || isJalE;
    assign btbIndex_o    = pcE[xlen-1:2];
    assign btbTarget_o   = pcE + immE;

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultM_o <= '0;
            writeDataM_o <= '0;
            pcPlus4M     <= '0;
            immM         <= '0;
            rdM_o        <= '0;
        end else begin
            aluResultM_o <= aluResultE;
            writeDataM_o <= writeDataE;
            pcPlus4M     <= pcE + 32'd4;
            immM         <= immE;
            rdM_o        <= rdE_o;
        end
    end

    // Loads never forward from memory, the load-use stall covers them
    always_comb begin
        case (resultSrcM_i)
            resPcPlus4: forwardDataM = pcPlus4M;
            resImm:     forwardDataM = immM;
            default:    forwardDataM = aluResultM_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultW <= '0;
            readDataW  <= '0;
            pcPlus4W   <= '0;
            immW       <= '0;
            rdW_o      <= '0;
        end else begin
            aluResultW <= aluResultM_o;
            readDataW  <= readDataM_i;
            pcPlus4W   <= pcPlus4M;
            immW       <= immM;
            rdW_o      <= rdM_o;
        end
    end

    always_comb begin
        case (resultSrcW_i)
            resMem:     resultW_o = readDataW;
            resPcPlus4: resultW_o = pcPlus4W;
            resImm:     resultW_o = immW;
            default:    resultW_o = aluResultW;
        endcase
    end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import riscvPkg::*; (
    input  logic            clk,
    input  logic [4:0]      addr1_i,
    input  logic [4:0]      addr2_i,
    input  logic [4:0]      addr3_i,
    input  logic            writeEn_i,
    input  logic [xlen-1:0] writeData_i,
    output logic [xlen-1:0] data1_o,
    output logic [xlen-1:0] data2_o
);

    logic [xlen-1:0] regs [32];

    // Falling edge write, so decode reads the new value in the same cycle
    always_ff @(negedge clk) begin
        if (writeEn_i && addr3_i != 5'd0) begin
            regs[addr3_i] <= writeData_i;
        end
    end

    // x0 is hardwired to zero
    assign data1_o = (addr1_i == 5'd0) ? '0 : regs[addr1_i];
    assign data2_o = (addr2_i == 5'd0) ? '0 : regs[addr2_i];

endmodule

// ==== src/riscvPkg.sv ====
package riscvPkg;

    // Datapath and predictor sizing
    localparam int xlen        = 32;
    localparam int bpIndexBits = 5;
    localparam int bpEntries   = 2 ** bpIndexBits;
    localparam int btbTagBits  = xlen - 2 - bpIndexBits;

    localparam logic [xlen-1:0] resetPc = '0;

    // Opcodes of the supported subset
    localparam logic [6:0] opRtype  = 7'b0110011;
    localparam logic [6:0] opItype  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt
    } aluOp_t;

    typedef enum logic [2:0] {
        immI, immS, immB, immJ, immU
    } immSrc_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwdReg, fwdWb, fwdMem
    } forwardSel_t;

    typedef enum logic [1:0] {
        resAlu, resMem, resPcPlus4, resImm
    } resultSrc_t;

endpackage

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk_o,
    output logic reset_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Reset spans five rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb/coreChecker.sv ====
`timescale 1ns/1ps

module coreChecker (
    input logic        clk_i,
    input logic        reset_i,
    input logic        memWrite_i,
    input logic        mispredict_i,
    input logic [31:0] pc_i
);

    assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown(memWrite_i))
        else $error("memWriteM_o is unknown");

    // A redirect flushes the younger instructions, so no back-to-back pulse
    assert property (@(posedge clk_i) disable iff (reset_i) mispredict_i |=> !mispredict_i)
        else $error("mispredictE_o high on two consecutive cycles");

    assert property (@(posedge clk_i) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else $error("pcF_o is not word aligned");

endmodule

bind pipelineCore coreChecker coreAsserts (
    .clk_i(clk),
    .reset_i(reset),
    .memWrite_i(memWriteM_o),
    .mispredict_i(mispredictE_o),
    .pc_i(pcF_o)
);

// ==== tb/coreTb.sv ====
`timescale 1ns/1ps

module coreTb import riscvPkg::*; ();

    logic clk;
    logic reset;
    logic [31:0] pcF;
    logic [31:0] instrF = 32'h00000013;
    logic [31:0] aluResultM;
    logic [31:0] writeDataM;
    logic memWriteM;
    logic [31:0] readDataM = 32'h0;
    logic mispredictE;

    // Header words, program, then one address/data pair per store
    logic [31:0] testData [0:63];
    logic [31:0] dataMem [0:63];
    int progLen;
    int loopLen;
    int expStores;
    int expMispredicts;
    int timeoutLimit;
    int cycles = 0;
    int storeIdx = 0;
    int mispredicts = 0;
    int drainCycles = 0;
    bit finalSeen = 1'b0;

    clockGen clockSource (
        .clk_o(clk),
        .reset_o(reset)
    );

    pipelineCore UUT (
        .clk(clk),
        .reset(reset),
        .pcF_o(pcF),
        .instrF_i(instrF),
        .aluResultM_o(aluResultM),
        .writeDataM_o(writeDataM),
        .memWriteM_o(memWriteM),
        .readDataM_i(readDataM),
        .mispredictE_o(mispredictE)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, expected);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    // Past the program the fetch sees nops
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < progLen) begin
            return testData[4 + idx];
        end
        return 32'h00000013;
    endfunction

    initial begin
        $readmemh("tb/coreTestdata.hex", testData);
        progLen        = int'(testData[0]);
        loopLen        = int'(testData[1]);
        expStores      = int'(testData[2]);
        expMispredicts = int'(testData[3]);
        timeoutLimit   = 4 * (progLen + 10 * loopLen);
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 32'h0;
        end
    end

    always @(negedge clk) begin
        // Memories answer from the state after the last rising edge
        instrF    <= fetchWord(pcF);
        readDataM <= dataMem[aluResultM[7:2]];
        cycles++;
        if (cycles > timeoutLimit) begin
            reportFailure("Timeout: the final store never appeared");
        end
        if (reset) begin
            assert (pcF == resetPc) else reportMismatch("pcF_o", pcF, resetPc);
            assert (memWriteM == 1'b0) else reportMismatch("memWriteM_o", 32'(memWriteM), 0);
            assert (mispredictE == 1'b0)
                else reportMismatch("mispredictE_o", 32'(mispredictE), 0);
        end else begin
            if (mispredictE) begin
                mispredicts++;
            end
            if (memWriteM) begin
                assert (storeIdx < expStores)
                    else reportFailure("A store appeared after the expected sequence ended");
                assert (aluResultM == testData[4 + progLen + 2 * storeIdx])
                    else reportMismatch("aluResultM_o", aluResultM,
                                        testData[4 + progLen + 2 * storeIdx]);
                assert (writeDataM == testData[5 + progLen + 2 * storeIdx])
                    else reportMismatch("writeDataM_o", writeDataM,
                                        testData[5 + progLen + 2 * storeIdx]);
                dataMem[aluResultM[7:2]] = writeDataM;
                storeIdx++;
                if (storeIdx == expStores) begin
                    finalSeen = 1'b1;
                end
            end
            if (finalSeen) begin
                drainCycles++;
            end
            // A few extra cycles expose any late wrong-path store
            if (drainCycles == 10) begin
                assert (mispredicts == expMispredicts)
                    else reportMismatch("mispredictCount", mispredicts, expMispredicts);
                $display("TESTBENCH PASSED");
                $finish;
            end
        end
    end

endmodule

// ==== tb/coreTestdata.hex ====
// Header: program words, loop words, store count, mispredict count
// Then program words, then one line per store with address and data
00000014
00000003
00000004
00000005
00A00093
00000113
04000293
00110133
FFF08093
FE009CE3
0022A023
0002A183
00118213
0042A223
12345337
004363B3
00000463
0002A423
0072A423
0043F433
0080056F
0002A623
008505B3
00B2A623
00000040 00000037
00000044 00000038
00000048 12345038
0000004C 0000007C
